//--- timerCountPkg.sv
`default_nettype none

package timerCountPkg;

    // Width shared by preset, count and bus data
    localparam int COUNT_WIDTH = 32;

    typedef logic [COUNT_WIDTH-1:0] countWord_t;

    // Counting modes, both hold values freeze the count
    typedef enum logic [1:0] {
        MODE_ONESHOT  = 2'd0, // Stops at zero
        MODE_PERIODIC = 2'd1, // Auto reload on zero
        MODE_HOLD2    = 2'd2,
        MODE_HOLD3    = 2'd3
    } timerMode_e;

endpackage

`default_nettype wire

//--- timerBusPkg.sv
`default_nettype none

package timerBusPkg;

    import timerCountPkg::*;

    // Word address: top bit is channel, low bits are register
    localparam int ADDR_WIDTH = 3;
    localparam int CHAN_BIT   = ADDR_WIDTH - 1;
    localparam int REG_WIDTH  = 2;

    // Implemented control bits, the rest read as zero
    localparam int CTRL_USED_BITS = 4;

    typedef enum logic [REG_WIDTH-1:0] {
        REG_CTRL   = 2'd0,
        REG_PRESET = 2'd1,
        REG_COUNT  = 2'd2  // Read only
    } regSel_e;

    typedef struct packed {
        logic [COUNT_WIDTH-CTRL_USED_BITS-1:0] reserved;
        logic                                  irqMask;
        timerMode_e                            mode;
        logic                                  enable;
    } ctrlWord_t;

    // One write word, decoded by the addressed register
    typedef union packed {
        ctrlWord_t  ctrl;
        countWord_t preset;
    } busWord_u;

endpackage

`default_nettype wire

//--- timerChannel.sv
`default_nettype none

module timerChannel
    import timerCountPkg::*, timerBusPkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       ctrlWr_i,
    input  logic       presetWr_i,
    input  regSel_e    regSel_i,
    input  ctrlWord_t  ctrlField_i,
    input  countWord_t presetVal_i,
    output countWord_t rdata_o,
    output logic       irq_o
);

    // Control fields
    logic       enable;
    timerMode_e mode;
    logic       irqMask;

    countWord_t preset;
    countWord_t count;
    logic       reloadPending; // Set by every preset write

    countWord_t countNext;
    logic       pendingNext;
    ctrlWord_t  ctrlRead;
    countWord_t readWord;

    // Count step, sees register values from before this edge
    always_comb begin
        countWord_t loaded;
        loaded      = count;
        countNext   = count;
        pendingNext = reloadPending;
        if (enable) begin
            case (mode)
                MODE_ONESHOT: begin
                    if (reloadPending) begin
                        loaded      = preset;
                        pendingNext = 1'b0;
                    end
                    countNext = (loaded != '0) ? loaded - 1 : loaded;
                end
                MODE_PERIODIC: begin
                    if (count == '0) begin
                        loaded = preset; // Wrap
                    end
                    countNext = (loaded != '0) ? loaded - 1 : loaded;
                end
                MODE_HOLD2, MODE_HOLD3: ; // Frozen, pending kept
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            enable        <= 1'b0;
            mode          <= MODE_ONESHOT;
            irqMask       <= 1'b0;
            preset        <= '0;
            count         <= '0;
            reloadPending <= 1'b0;
        end else begin
            count         <= countNext;
            reloadPending <= presetWr_i | pendingNext; // New write wins over a clear
            if (ctrlWr_i) begin
                enable  <= ctrlField_i.enable;
                mode    <= ctrlField_i.mode;
                irqMask <= ctrlField_i.irqMask;
            end
            if (presetWr_i) begin
                preset <= presetVal_i;
            end
        end
    end

    // Control readback with reserved bits as zero
    assign ctrlRead = '{reserved: '0, irqMask: irqMask, mode: mode, enable: enable};

    always_comb begin
        case (regSel_i)
            REG_CTRL:   readWord = ctrlRead;
            REG_PRESET: readWord = preset;
            REG_COUNT:  readWord = count;
            default:    readWord = '0; // Index 3
        endcase
    end

    // One cycle behind the address
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= readWord;
        end
    end

    // Level interrupt, one-shot only
    assign irq_o = irqMask && (mode == MODE_ONESHOT) && (count == '0);

endmodule

`default_nettype wire

//--- timerBusMux.sv
`default_nettype none

module timerBusMux
    import timerCountPkg::*, timerBusPkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic                  we_i,
    input  countWord_t            wdata_i,
    input  countWord_t            rdata0_i,
    input  countWord_t            rdata1_i,
    input  logic                  irq0_i,
    input  logic                  irq1_i,
    output logic                  ctrlWr0_o,
    output logic                  presetWr0_o,
    output logic                  ctrlWr1_o,
    output logic                  presetWr1_o,
    output regSel_e               regSel_o,
    output ctrlWord_t             ctrlField_o,
    output countWord_t            presetVal_o,
    output countWord_t            rdata_o,
    output logic                  irq_o
);

    logic     chanSel;
    logic     chanSelQ; // Channel of last cycle's read
    regSel_e  regIdx;
    logic     ctrlWr;
    logic     presetWr;
    busWord_u wordView;

    // Address split
    assign chanSel  = addr_i[CHAN_BIT];
    assign regIdx   = regSel_e'(addr_i[REG_WIDTH-1:0]);
    assign regSel_o = regIdx;

    // Count register and index 3 produce no strobe
    assign ctrlWr   = we_i && (regIdx == REG_CTRL);
    assign presetWr = we_i && (regIdx == REG_PRESET);

    assign ctrlWr0_o   = ctrlWr && !chanSel;
    assign presetWr0_o = presetWr && !chanSel;
    assign ctrlWr1_o   = ctrlWr && chanSel;
    assign presetWr1_o = presetWr && chanSel;

    // Same write word seen both ways
    assign wordView    = busWord_u'(wdata_i);
    assign ctrlField_o = wordView.ctrl;
    assign presetVal_o = wordView.preset;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            chanSelQ <= 1'b0;
        end else begin
            chanSelQ <= chanSel;
        end
    end

    // Both inputs already registered in the channels
    assign rdata_o = chanSelQ ? rdata1_i : rdata0_i;

    assign irq_o = irq0_i | irq1_i;

endmodule

`default_nettype wire

//--- dualTimer.sv
`default_nettype none

module dualTimer
    import timerCountPkg::*, timerBusPkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic                  we_i,
    input  countWord_t            wdata_i,
    output countWord_t            rdata_o,
    output logic                  irq_o
);

    logic       ctrlWr0;
    logic       presetWr0;
    logic       ctrlWr1;
    logic       presetWr1;
    regSel_e    regSel;
    ctrlWord_t  ctrlField;
    countWord_t presetVal;
    countWord_t rdata0;
    countWord_t rdata1;
    logic       irq0;
    logic       irq1;

    timerChannel channel0 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ctrlWr_i    (ctrlWr0),
        .presetWr_i  (presetWr0),
        .regSel_i    (regSel),
        .ctrlField_i (ctrlField),
        .presetVal_i (presetVal),
        .rdata_o     (rdata0),
        .irq_o       (irq0)
    );

    timerChannel channel1 (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ctrlWr_i    (ctrlWr1),
        .presetWr_i  (presetWr1),
        .regSel_i    (regSel),
        .ctrlField_i (ctrlField),
        .presetVal_i (presetVal),
        .rdata_o     (rdata1),
        .irq_o       (irq1)
    );

    // Write decode, read select and interrupt OR
    timerBusMux busMux (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .addr_i      (addr_i),
        .we_i        (we_i),
        .wdata_i     (wdata_i),
        .rdata0_i    (rdata0),
        .rdata1_i    (rdata1),
        .irq0_i      (irq0),
        .irq1_i      (irq1),
        .ctrlWr0_o   (ctrlWr0),
        .presetWr0_o (presetWr0),
        .ctrlWr1_o   (ctrlWr1),
        .presetWr1_o (presetWr1),
        .regSel_o    (regSel),
        .ctrlField_o (ctrlField),
        .presetVal_o (presetVal),
        .rdata_o     (rdata_o),
        .irq_o       (irq_o)
    );

endmodule

`default_nettype wire

//--- dualTimer_sva.sv
`default_nettype none

module timerChannelSva
    import timerCountPkg::*;
(
    input logic       clk_i,
    input logic       rst_i,
    input logic       ctrlWr_i,
    input logic       presetWr_i,
    input timerMode_e mode_i,
    input logic       irqMask_i,
    input countWord_t count_i,
    input logic       reloadPending_i,
    input logic       irq_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // A rise needs a pending reload or a periodic wrap from zero
    countRisesOnLoad: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (count_i > $past(count_i)) |-> ($past(reloadPending_i) || $past(count_i) == '0)
    ) else $error("Count increased without a preset load");

    zeroHoldsInOneShot: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (mode_i == MODE_ONESHOT && count_i == '0 && !reloadPending_i && !presetWr_i)
            |=> (count_i == '0)
    ) else $error("One-shot count left zero without a preset write");

    // Mask only changes through a control write
    noIrqWithoutMask: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (!irqMask_i && !ctrlWr_i) |=> !irq_i
    ) else $error("Channel interrupt high while irqMask stayed clear");

endmodule

bind timerChannel timerChannelSva channelSva (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .ctrlWr_i        (ctrlWr_i),
    .presetWr_i      (presetWr_i),
    .mode_i          (mode),
    .irqMask_i       (irqMask),
    .count_i         (count),
    .reloadPending_i (reloadPending),
    .irq_i           (irq_o)
);

`default_nettype wire

//--- dualTimer_tb.sv
`default_nettype none

module dualTimer_tb
    import timerCountPkg::*, timerBusPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_CYCLES = 400;
    // Readback 20, one-shot 21, periodic 24, hold 40, random, tail 3
    localparam int PLANNED_CYCLES = RESET_CYCLES + 20 + 21 + 24 + 40 + RANDOM_CYCLES + 3;
    localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;

    logic                  clk_i;
    logic                  rst_i;
    logic [ADDR_WIDTH-1:0] addr_i;
    logic                  we_i;
    countWord_t            wdata_i;
    countWord_t            rdata_o;
    logic                  irq_o;

    // Model state per channel
    ctrlWord_t  mCtrl [2];
    countWord_t mPreset [2];
    countWord_t mCount [2];
    logic       mPend [2];

    countWord_t  expRdata = '0;
    logic        expIrq = 1'b0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    logic [31:0] rngState = 32'd9;

    dualTimer uut (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .addr_i  (addr_i),
        .we_i    (we_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .irq_o   (irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One count step, returns {pending, count}
    function automatic logic [COUNT_WIDTH:0] nextCount(input ctrlWord_t ctrl,
            input countWord_t preset, input countWord_t count, input logic pending);
        countWord_t c;
        logic       p;
        c = count;
        p = pending;
        if (ctrl.enable && ctrl.mode == MODE_ONESHOT) begin
            if (p) begin
                c = preset;
                p = 1'b0;
            end
            if (c != '0) c = c - 1;
        end else if (ctrl.enable && ctrl.mode == MODE_PERIODIC) begin
            if (c == '0) c = preset; // Wrap
            if (c != '0) c = c - 1;
        end
        return {p, c};
    endfunction

    function automatic countWord_t readModel(input logic [ADDR_WIDTH-1:0] addr);
        int ch;
        ch = addr[CHAN_BIT];
        case (addr[REG_WIDTH-1:0])
            2'd0:    return countWord_t'(mCtrl[ch]);
            2'd1:    return mPreset[ch];
            2'd2:    return mCount[ch];
            default: return '0;
        endcase
    endfunction

    function automatic logic chanIrq(input int ch);
        return mCtrl[ch].irqMask && mCtrl[ch].mode == MODE_ONESHOT && mCount[ch] == '0;
    endfunction

    task automatic checkWord(input string name, input countWord_t expected,
            input countWord_t actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkIrq(input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch at %0t: irq_o expected %b, got %b", $time, expected, actual);
        end
    endtask

    // Outputs of the last edge first, then the model steps for the next edge
    always @(negedge clk_i) begin : compareModel
        logic [COUNT_WIDTH:0] step;
        checkWord("rdata_o", expRdata, rdata_o);
        checkIrq(expIrq, irq_o);
        if (rst_i) begin
            for (int ch = 0; ch < 2; ch++) begin
                mCtrl[ch]   = '0;
                mPreset[ch] = '0;
                mCount[ch]  = '0;
                mPend[ch]   = 1'b0;
            end
            expRdata = '0;
            expIrq   = 1'b0;
        end else begin
            expRdata = readModel(addr_i); // Values from before the edge
            for (int ch = 0; ch < 2; ch++) begin
                step        = nextCount(mCtrl[ch], mPreset[ch], mCount[ch], mPend[ch]);
                mCount[ch]  = step[COUNT_WIDTH-1:0];
                mPend[ch]   = step[COUNT_WIDTH];
                if (we_i && addr_i[CHAN_BIT] == ch) begin
                    if (addr_i[REG_WIDTH-1:0] == REG_CTRL) begin
                        mCtrl[ch] = ctrlWord_t'(wdata_i & 32'h0000_000F); // Low 4 bits kept
                    end else if (addr_i[REG_WIDTH-1:0] == REG_PRESET) begin
                        mPreset[ch] = wdata_i;
                        mPend[ch]   = 1'b1;
                    end
                end
            end
            expIrq = chanIrq(0) | chanIrq(1);
        end
    end

    always @(posedge clk_i) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout: the test sequence did not finish within %0d cycles", cycleCount);
            $display("Checks: %0d, errors: %0d", checkCount, errorCount);
            $display("tests failed");
            $finish;
        end
    end

    task automatic busCycle(input logic [ADDR_WIDTH-1:0] addr, input logic we,
            input countWord_t data);
        @(posedge clk_i);
        addr_i  <= addr;
        we_i    <= we;
        wdata_i <= data;
    endtask

    task automatic writeReg(input logic [ADDR_WIDTH-1:0] addr, input countWord_t data);
        busCycle(addr, 1'b1, data);
    endtask

    task automatic readFor(input logic [ADDR_WIDTH-1:0] addr, input int cycles);
        repeat (cycles) busCycle(addr, 1'b0, '0);
    endtask

    initial begin : stimulus
        logic [31:0] addrWe;
        addr_i  = '0;
        we_i    = 1'b0;
        wdata_i = '0;
        rst_i   = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        // Reset values, then readback width
        for (int a = 0; a < 8; a++) readFor(a[ADDR_WIDTH-1:0], 1);
        writeReg(3'd0, 32'hDEAD_BEE4);
        writeReg(3'd1, 32'hCAFE_F00D);
        writeReg(3'd4, 32'h1234_567A);
        writeReg(3'd5, 32'hFFFF_FFFF);
        for (int a = 0; a < 8; a++) readFor(a[ADDR_WIDTH-1:0], 1);

        writeReg(3'd0, 32'h0000_0009); // Channel 0 one-shot with mask
        writeReg(3'd1, 32'd5);
        readFor(3'd2, 9);
        writeReg(3'd1, 32'd5);         // Same value still reloads
        readFor(3'd2, 9);

        writeReg(3'd0, 32'h0000_0000);
        writeReg(3'd5, 32'd3);
        writeReg(3'd4, 32'h0000_000B); // Channel 1 periodic, mask set
        readFor(3'd6, 12);
        writeReg(3'd5, 32'd0);
        readFor(3'd6, 8);

        writeReg(3'd1, 32'd20);
        writeReg(3'd0, 32'h0000_0001);
        readFor(3'd2, 4);
        writeReg(3'd0, 32'h0000_0000); // Stopped
        writeReg(3'd1, 32'd7);         // Reload waits
        readFor(3'd2, 4);
        writeReg(3'd0, 32'h0000_000D); // Mode 2
        readFor(3'd2, 4);
        writeReg(3'd0, 32'h0000_000F); // Mode 3
        readFor(3'd2, 4);
        writeReg(3'd2, 32'hFFFF_FFFF);
        writeReg(3'd3, 32'hFFFF_FFFF);
        writeReg(3'd7, 32'hFFFF_FFFF);
        readFor(3'd3, 2);
        readFor(3'd7, 2);
        writeReg(3'd0, 32'h0000_0009);
        readFor(3'd2, 10);

        repeat (RANDOM_CYCLES) begin
            rngState = xorshift(rngState);
            addrWe   = rngState;
            rngState = xorshift(rngState);
            // Mostly short presets so counts reach zero
            busCycle(addrWe[2:0], addrWe[5:4] == 2'b00,
                rngState[31] ? rngState : (rngState & 32'h0000_001F));
        end

        readFor(3'd0, 2);
        @(posedge clk_i);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dualTimer.f
timerCountPkg.sv
timerBusPkg.sv
timerChannel.sv
timerBusMux.sv
dualTimer.sv
dualTimer_sva.sv
dualTimer_tb.sv

//--- Bender.yml
package:
  name: dualTimer

sources:
  - timerCountPkg.sv
  - timerBusPkg.sv
  - timerChannel.sv
  - timerBusMux.sv
  - dualTimer.sv
  - target: test
    files:
      - dualTimer_sva.sv
      - dualTimer_tb.sv
